// ==== design/arith_pkg.sv ====
package arith_pkg;

    // Operand and slice geometry
    localparam int DATA_WIDTH  = 64;
    localparam int SLICE_WIDTH = 16;
    localparam int NUM_SLICES  = DATA_WIDTH / SLICE_WIDTH;

    // One slice resolves per clock
    localparam int ADD_LATENCY  = NUM_SLICES;
    localparam int UNIT_LATENCY = ADD_LATENCY + 2;   // Operand stage and format stage

    // Opcodes; encoding 3 is unused and decodes as an add
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,   // a + b
        OP_SUB  = 2'd1,   // a - b
        OP_RSUB = 2'd2    // b - a
    } alu_op_e;

endpackage

// ==== design/stream_pkg.sv ====
package stream_pkg;

    import arith_pkg::*;

    // Request as seen at the unit boundary
    typedef struct packed {
        alu_op_e               op;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
    } add_req_t;

    // Adder inputs after inversion
    typedef struct packed {
        logic [DATA_WIDTH-1:0] x;
        logic [DATA_WIDTH-1:0] y;
        logic                  cin;
    } add_operands_t;

    // Travels beside the sum through the adder
    typedef struct packed {
        alu_op_e op;
        logic    sign_x;
        logic    sign_y;
    } add_side_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] sum;
        logic                  carry;   // Top carry out, 1 means no borrow on subtract
        logic                  zero;
        logic                  neg;
        logic                  ovf;     // Signed overflow
    } add_rsp_t;

endpackage

// ==== design/operand_prep.sv ====
`timescale 1ns/1ps

module operand_prep
    import arith_pkg::*, stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  add_req_t      req,
    output logic          prep_valid,
    output add_operands_t prep_ops,
    output add_side_t     prep_side
);

    add_operands_t ops_d;
    add_side_t     side_d;

    // Subtraction as x + ~y + 1
    always_comb begin
        case (req.op)
            OP_SUB: begin
                ops_d.x   = req.a;
                ops_d.y   = ~req.b;
                ops_d.cin = 1'b1;
            end
            OP_RSUB: begin
                ops_d.x   = req.b;
                ops_d.y   = ~req.a;
                ops_d.cin = 1'b1;
            end
            default: begin   // OP_ADD and the unused encoding
                ops_d.x   = req.a;
                ops_d.y   = req.b;
                ops_d.cin = 1'b0;
            end
        endcase
    end

    // Signs after inversion, for the overflow rule
    always_comb begin
        side_d.op     = req.op;
        side_d.sign_x = ops_d.x[DATA_WIDTH-1];
        side_d.sign_y = ops_d.y[DATA_WIDTH-1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prep_valid <= 1'b0;
        end else begin
            prep_valid <= in_valid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prep_ops  <= '0;
            prep_side <= '0;
        end else if (in_valid) begin
            prep_ops  <= ops_d;
            prep_side <= side_d;
        end
    end

endmodule

// ==== design/carry_slice_adder.sv ====
`timescale 1ns/1ps

module carry_slice_adder
    import arith_pkg::*, stream_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  prep_valid,
    input  add_operands_t         prep_ops,
    input  add_side_t             prep_side,
    output logic                  sum_valid,
    output logic [DATA_WIDTH:0]   sum_out,
    output add_side_t             sum_side
);

    logic [NUM_SLICES-1:0]  slice_en;    // Enable of slice k
    logic [NUM_SLICES-1:0]  en_q;
    logic                   slice_carry [NUM_SLICES];
    logic [SLICE_WIDTH-1:0] slice_sum   [NUM_SLICES];
    logic [SLICE_WIDTH-1:0] aligned     [NUM_SLICES];
    add_side_t              side_q      [ADD_LATENCY];

    // Strobe walks up one slice per cycle
    always_comb begin
        slice_en[0] = prep_valid;
        for (int k = 1; k < NUM_SLICES; k++) begin
            slice_en[k] = en_q[k-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q <= '0;
        end else begin
            en_q <= slice_en;
        end
    end

    assign sum_valid = en_q[NUM_SLICES-1];

    for (genvar k = 0; k < NUM_SLICES; k++) begin : g_slice
        localparam int LO     = k * SLICE_WIDTH;
        localparam int DESKEW = NUM_SLICES - 1 - k;

        logic [SLICE_WIDTH-1:0] x_s;
        logic [SLICE_WIDTH-1:0] y_s;
        logic                   c_in;

        if (k == 0) begin : g_direct
            assign x_s  = prep_ops.x[LO +: SLICE_WIDTH];
            assign y_s  = prep_ops.y[LO +: SLICE_WIDTH];
            assign c_in = prep_ops.cin;
        end else begin : g_skew
            logic [SLICE_WIDTH-1:0] x_q [k];
            logic [SLICE_WIDTH-1:0] y_q [k];

            // Operand slice waits k cycles for its carry
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < k; i++) begin
                        x_q[i] <= '0;
                        y_q[i] <= '0;
                    end
                end else begin
                    x_q[0] <= prep_ops.x[LO +: SLICE_WIDTH];
                    y_q[0] <= prep_ops.y[LO +: SLICE_WIDTH];
                    for (int i = 1; i < k; i++) begin
                        x_q[i] <= x_q[i-1];
                        y_q[i] <= y_q[i-1];
                    end
                end
            end

            assign x_s  = x_q[k-1];
            assign y_s  = y_q[k-1];
            assign c_in = slice_carry[k-1];   // Registered by the slice below
        end

        // Holds its value when the strobe is low
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                slice_carry[k] <= 1'b0;
                slice_sum[k]   <= '0;
            end else if (slice_en[k]) begin
                {slice_carry[k], slice_sum[k]} <= {1'b0, x_s} + {1'b0, y_s} + c_in;
            end
        end

        if (DESKEW == 0) begin : g_top
            assign aligned[k] = slice_sum[k];
        end else begin : g_deskew
            logic [SLICE_WIDTH-1:0] s_q [DESKEW];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < DESKEW; i++) begin
                        s_q[i] <= '0;
                    end
                end else begin
                    s_q[0] <= slice_sum[k];
                    for (int i = 1; i < DESKEW; i++) begin
                        s_q[i] <= s_q[i-1];
                    end
                end
            end

            assign aligned[k] = s_q[DESKEW-1];
        end
    end

    always_comb begin
        sum_out[DATA_WIDTH] = slice_carry[NUM_SLICES-1];
        for (int k = 0; k < NUM_SLICES; k++) begin
            sum_out[k*SLICE_WIDTH +: SLICE_WIDTH] = aligned[k];
        end
    end

    // Sideband matches the adder latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ADD_LATENCY; i++) begin
                side_q[i] <= '0;
            end
        end else begin
            side_q[0] <= prep_side;
            for (int i = 1; i < ADD_LATENCY; i++) begin
                side_q[i] <= side_q[i-1];
            end
        end
    end

    assign sum_side = side_q[ADD_LATENCY-1];

endmodule

// ==== design/result_format.sv ====
`timescale 1ns/1ps

module result_format
    import arith_pkg::*, stream_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sum_valid,
    input  logic [DATA_WIDTH:0] sum_out,
    input  add_side_t           sum_side,
    output logic                out_valid,
    output add_rsp_t            rsp
);

    add_rsp_t rsp_d;
    logic     sum_sign;

    assign sum_sign = sum_out[DATA_WIDTH-1];

    always_comb begin
        rsp_d.sum   = sum_out[DATA_WIDTH-1:0];
        rsp_d.carry = sum_out[DATA_WIDTH];
        rsp_d.zero  = ~|sum_out[DATA_WIDTH-1:0];
        rsp_d.neg   = sum_sign;
        // Like-signed inputs giving an opposite-signed sum
        rsp_d.ovf   = (sum_side.sign_x == sum_side.sign_y) &&
                      (sum_sign != sum_side.sign_x);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sum_valid;
        end
    end

    // Result holds between operations
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp <= '0;
        end else if (sum_valid) begin
            rsp <= rsp_d;
        end
    end

endmodule

// ==== design/add_unit_top.sv ====
`timescale 1ns/1ps

module add_unit_top
    import arith_pkg::*, stream_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  add_req_t req,
    output logic     out_valid,
    output add_rsp_t rsp
);

    logic                prep_valid;
    add_operands_t       prep_ops;
    add_side_t           prep_side;

    logic                sum_valid;
    logic [DATA_WIDTH:0] sum_out;    // Carry on top
    add_side_t           sum_side;

    operand_prep u_prep (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .req        (req),
        .prep_valid (prep_valid),
        .prep_ops   (prep_ops),
        .prep_side  (prep_side)
    );

    // ADD_LATENCY cycles, one slice per clock
    carry_slice_adder u_adder (
        .clk        (clk),
        .rst_n      (rst_n),
        .prep_valid (prep_valid),
        .prep_ops   (prep_ops),
        .prep_side  (prep_side),
        .sum_valid  (sum_valid),
        .sum_out    (sum_out),
        .sum_side   (sum_side)
    );

    result_format u_format (
        .clk        (clk),
        .rst_n      (rst_n),
        .sum_valid  (sum_valid),
        .sum_out    (sum_out),
        .sum_side   (sum_side),
        .out_valid  (out_valid),
        .rsp        (rsp)
    );

endmodule

// ==== test/add_unit_chk.sv ====
`timescale 1ns/1ps

module add_unit_chk
    import arith_pkg::*, stream_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     in_valid,
    input logic     out_valid,
    input add_rsp_t rsp
);

    // Fixed pipeline depth, no stalls
    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> ##UNIT_LATENCY out_valid
    ) else $error("out_valid did not follow in_valid after the unit latency");

    a_reset_quiet: assert property (
        @(posedge clk) !rst_n |-> !out_valid
    ) else $error("out_valid high while reset is asserted");

    a_zero_flag: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> (rsp.zero == (rsp.sum == '0))
    ) else $error("zero flag does not match the sum");

endmodule

bind add_unit_top add_unit_chk chk0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .rsp       (rsp)
);

// ==== test/add_unit_tb.sv ====
`timescale 1ns/1ps

module add_unit_tb
    import arith_pkg::*, stream_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 6;
    localparam int MAX_GAP      = 3;
    localparam int SETTLE       = UNIT_LATENCY + 4;   // Idle tail that catches stray results
    localparam int REQ_CYCLES   = 5 + 6 + 6 + 200 + 200 * (MAX_GAP + 1) + 20 + 1;
    localparam int TIMEOUT      = REQ_CYCLES + (UNIT_LATENCY + SETTLE) * NUM_TESTS
                                  + 2 * RESET_CYCLES + 100;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    add_req_t req;
    logic     out_valid;
    add_rsp_t rsp;

    add_rsp_t exp_q[$];
    add_rsp_t want;
    integer   seed = 75441;
    int       errors;
    int       err_mark;
    int       pass_tests;
    int       fail_tests;
    int       cycles;

    add_unit_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected result straight from the arithmetic
    function automatic add_rsp_t expected_rsp(add_req_t r);
        logic [DATA_WIDTH-1:0] p;
        logic [DATA_WIDTH-1:0] q;
        logic [DATA_WIDTH:0]   wide;
        add_rsp_t              e;
        p = (r.op == OP_RSUB) ? r.b : r.a;
        q = (r.op == OP_RSUB) ? r.a : r.b;
        if (r.op == OP_SUB || r.op == OP_RSUB) begin
            e.sum   = p - q;
            e.carry = (p >= q);   // No borrow
            e.ovf   = (p[DATA_WIDTH-1] != q[DATA_WIDTH-1]) &&
                      (e.sum[DATA_WIDTH-1] != p[DATA_WIDTH-1]);
        end else begin
            wide    = {1'b0, p} + {1'b0, q};
            e.sum   = wide[DATA_WIDTH-1:0];
            e.carry = wide[DATA_WIDTH];
            e.ovf   = (p[DATA_WIDTH-1] == q[DATA_WIDTH-1]) &&
                      (e.sum[DATA_WIDTH-1] != p[DATA_WIDTH-1]);
        end
        e.zero = (e.sum == '0);
        e.neg  = e.sum[DATA_WIDTH-1];
        return e;
    endfunction

    task automatic check_field(string name, logic [DATA_WIDTH-1:0] exp_v,
                               logic [DATA_WIDTH-1:0] act_v);
        assert (act_v == exp_v) else begin
            $display("[ERROR] rsp.%s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic drive_op(alu_op_e op, logic [DATA_WIDTH-1:0] a, logic [DATA_WIDTH-1:0] b);
        in_valid <= 1'b1;
        req.op   <= op;
        req.a    <= a;
        req.b    <= b;
        @(posedge clk);
    endtask

    task automatic drive_random();
        logic [1:0] op_bits;
        op_bits = 2'($unsigned($random(seed)));   // Encoding 3 included on purpose
        drive_op(alu_op_e'(op_bits), {$random(seed), $random(seed)},
                 {$random(seed), $random(seed)});
    endtask

    task automatic idle_cycle();
        in_valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic finish_test(string name);
        in_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (SETTLE) @(posedge clk);
        if (errors == err_mark) begin
            pass_tests++;
            $display("Test %s: passed", name);
        end else begin
            fail_tests++;
            $display("Test %s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // Requests seen on the accepting edge
    always @(posedge clk) begin
        if (rst_n && in_valid)
            exp_q.push_back(expected_rsp(req));
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            assert (!out_valid) else begin
                $display("out_valid was high while reset was asserted");
                errors++;
            end
        end else if (out_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("Unexpected result with no request outstanding, sum 0x%0h", rsp.sum);
                errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                check_field("sum", want.sum, rsp.sum);
                check_field("carry", want.carry, rsp.carry);
                check_field("zero", want.zero, rsp.zero);
                check_field("neg", want.neg, rsp.neg);
                check_field("ovf", want.ovf, rsp.ovf);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run hung, no completion after %0d cycles", TIMEOUT);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n      <= 1'b0;
        in_valid   <= 1'b0;
        req        <= '0;
        errors     = 0;
        err_mark   = 0;
        pass_tests = 0;
        fail_tests = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        drive_op(OP_ADD, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1);   // Ripple through every slice
        drive_op(OP_ADD, 64'h0000_0000_0000_FFFF, 64'h1);
        drive_op(OP_ADD, 64'h0000_FFFF_FFFF_0000, 64'h0000_0000_0001_0000);
        drive_op(OP_ADD, 64'h1234_5678_9ABC_DEF0, 64'h0FED_CBA9_8765_4321);
        drive_op(OP_ADD, 64'h0, 64'h0);
        finish_test("directed add");

        drive_op(OP_SUB, 64'hDEAD_BEEF_0000_1111, 64'hDEAD_BEEF_0000_1111);
        drive_op(OP_SUB, 64'h5, 64'h9);
        drive_op(OP_SUB, 64'h0001_0000_0000_0000, 64'h1);
        drive_op(OP_RSUB, 64'hDEAD_BEEF_0000_1111, 64'hDEAD_BEEF_0000_1111);
        drive_op(OP_RSUB, 64'h5, 64'h9);
        drive_op(OP_RSUB, 64'h9, 64'h5);
        finish_test("directed subtract and reverse subtract");

        drive_op(OP_ADD, 64'h7FFF_FFFF_FFFF_FFFF, 64'h1);
        drive_op(OP_SUB, 64'h8000_0000_0000_0000, 64'h1);
        drive_op(OP_RSUB, 64'h1, 64'h8000_0000_0000_0000);
        drive_op(OP_SUB, 64'h7FFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF);
        drive_op(OP_ADD, 64'h7FFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000);
        drive_op(OP_ADD, 64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF);
        finish_test("signed overflow");

        repeat (200) drive_random();
        finish_test("back-to-back stream");

        repeat (200) begin
            drive_random();
            repeat ($unsigned($random(seed)) % (MAX_GAP + 1)) idle_cycle();
        end
        finish_test("gapped stream");

        repeat (20) drive_random();
        rst_n    <= 1'b0;
        in_valid <= 1'b0;
        repeat (4) @(posedge clk);
        exp_q.delete();   // Operations in flight are lost
        rst_n <= 1'b1;
        @(posedge clk);
        drive_op(OP_SUB, 64'h0000_0001_0000_0000, 64'h1);
        finish_test("reset in flight");

        $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_tests, fail_tests, errors);
        if (fail_tests == 0 && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/arith_pkg.sv
design/stream_pkg.sv
design/operand_prep.sv
design/carry_slice_adder.sv
design/result_format.sv
design/add_unit_top.sv
test/add_unit_chk.sv
test/add_unit_tb.sv
